// File: hdl/bus_pkg.sv
package bus_pkg;

	////////////////////
	// widths
	////////////////////

	localparam int addr_w = 32;
	localparam int data_w = 64;
	localparam int strb_w = data_w / 8;

	////////////////////
	// enums
	////////////////////

	typedef enum logic [1:0] {
		okay   = 2'b00,
		exokay = 2'b01,
		slverr = 2'b10,
		decerr = 2'b11
	} resp_e;

	// owner of the shared read path.
	typedef enum logic [1:0] {
		idle     = 2'b00,
		ifu_busy = 2'b01,
		lsu_busy = 2'b10
	} grant_e;

	////////////////////
	// channel payloads
	////////////////////

	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [2:0]        size;
	} ar_t;

	typedef struct packed {
		logic [data_w-1:0] data;
		resp_e             resp;
	} r_t;

	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [2:0]        size;
	} aw_t;

	typedef struct packed {
		logic [data_w-1:0] data;
		logic [strb_w-1:0] strb;
	} w_t;

	typedef struct packed {
		resp_e resp;
	} b_t;

	// full SoC address payload, also used for AW since the fields are the same.
	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [3:0]        id;
		logic [7:0]        len;
		logic [2:0]        size;
		logic [1:0]        burst;
	} axi_ar_t;

	typedef struct packed {
		logic [data_w-1:0] data;
		logic [strb_w-1:0] strb;
		logic              last;
	} axi_w_t;

endpackage

// File: hdl/read_arbiter.sv
`timescale 1ns/1ns

module read_arbiter (
	input  logic             clock,
	input  logic             reset,
	input  logic             ifu_req,
	input  logic             lsu_req,
	input  logic             ifu_done,
	input  logic             lsu_done,
	output bus_pkg::grant_e  grant
);

	bus_pkg::grant_e state;
	bus_pkg::grant_e state_next;

	////////////////////
	// next state
	////////////////////

	always_comb begin
		state_next = state;
		case (state)
			bus_pkg::idle: begin
				if (ifu_req) begin
					state_next = bus_pkg::ifu_busy; // fetch wins a tie.
				end else if (lsu_req) begin
					state_next = bus_pkg::lsu_busy;
				end
			end
			bus_pkg::ifu_busy: begin
				if (ifu_done) begin
					state_next = bus_pkg::idle;
				end
			end
			bus_pkg::lsu_busy: begin
				if (lsu_done) begin
					state_next = bus_pkg::idle;
				end
			end
			default: begin
				state_next = bus_pkg::idle;
			end
		endcase
	end

	////////////////////
	// state register
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= bus_pkg::idle;
		end else begin
			state <= state_next;
		end
	end

	assign grant = state;

endmodule

// File: hdl/xbar.sv
`timescale 1ns/1ns

module xbar #(
	parameter logic [bus_pkg::addr_w-1:0] CLINT_BASE = 32'h0200_0000,
	parameter logic [bus_pkg::addr_w-1:0] CLINT_LAST = 32'h0200_ffff
) (
	input  logic                         clock,
	input  logic                         reset,

	input  bus_pkg::ar_t                 ifu_ar,
	input  logic                         ifu_ar_valid,
	output logic                         ifu_ar_ready,
	output bus_pkg::r_t                  ifu_r,
	output logic                         ifu_r_valid,
	input  logic                         ifu_r_ready,

	input  bus_pkg::ar_t                 lsu_ar,
	input  logic                         lsu_ar_valid,
	output logic                         lsu_ar_ready,
	output bus_pkg::r_t                  lsu_r,
	output logic                         lsu_r_valid,
	input  logic                         lsu_r_ready,

	input  bus_pkg::aw_t                 lsu_aw,
	input  logic                         lsu_aw_valid,
	output logic                         lsu_aw_ready,
	input  bus_pkg::w_t                  lsu_w,
	input  logic                         lsu_w_valid,
	output logic                         lsu_w_ready,
	output bus_pkg::b_t                  lsu_b,
	output logic                         lsu_b_valid,
	input  logic                         lsu_b_ready,

	output bus_pkg::axi_ar_t             soc_ar,
	output logic                         soc_ar_valid,
	input  logic                         soc_ar_ready,
	input  bus_pkg::r_t                  soc_r,
	input  logic                         soc_r_valid,
	output logic                         soc_r_ready,
	output bus_pkg::axi_ar_t             soc_aw,
	output logic                         soc_aw_valid,
	input  logic                         soc_aw_ready,
	output bus_pkg::axi_w_t              soc_w,
	output logic                         soc_w_valid,
	input  logic                         soc_w_ready,
	input  bus_pkg::b_t                  soc_b,
	input  logic                         soc_b_valid,
	output logic                         soc_b_ready,

	output logic [bus_pkg::addr_w-1:0]   clint_ar_addr,
	output logic                         clint_ar_valid,
	input  logic                         clint_ar_ready,
	input  logic [31:0]                  clint_r_data,
	input  bus_pkg::resp_e               clint_r_resp,
	input  logic                         clint_r_valid,
	output logic                         clint_r_ready
);

	localparam logic [2:0] IFU_SIZE = 3'b010;

	bus_pkg::grant_e grant;
	logic ifu_own, lsu_own;
	logic lsu_hit_clint;
	logic ar_sent;  // address phase of the current grant is done.
	logic to_clint; // target of the lsu read, latched at its AR transfer.
	logic ifu_ar_xfer, lsu_ar_xfer;
	logic ifu_done, lsu_done;

	read_arbiter read_arbiter_inst (
		.clock    (clock),
		.reset    (reset),
		.ifu_req  (ifu_ar_valid),
		.lsu_req  (lsu_ar_valid),
		.ifu_done (ifu_done),
		.lsu_done (lsu_done),
		.grant    (grant)
	);

	assign ifu_own = (grant == bus_pkg::ifu_busy);
	assign lsu_own = (grant == bus_pkg::lsu_busy);
	assign lsu_hit_clint = (lsu_ar.addr >= CLINT_BASE) && (lsu_ar.addr <= CLINT_LAST);

	////////////////////
	// read address
	////////////////////

	assign soc_ar_valid = !ar_sent && (ifu_own && ifu_ar_valid ||
		lsu_own && !lsu_hit_clint && lsu_ar_valid);
	assign clint_ar_valid = !ar_sent && lsu_own && lsu_hit_clint && lsu_ar_valid;
	assign clint_ar_addr = lsu_ar.addr;

	assign ifu_ar_ready = !ar_sent && ifu_own && soc_ar_ready;
	assign lsu_ar_ready = !ar_sent && lsu_own && (lsu_hit_clint ? clint_ar_ready : soc_ar_ready);

	always_comb begin
		soc_ar.addr  = ifu_own ? ifu_ar.addr : lsu_ar.addr;
		soc_ar.size  = ifu_own ? IFU_SIZE : lsu_ar.size; // fetches are always one word.
		soc_ar.id    = 4'd0;
		soc_ar.len   = 8'd0;
		soc_ar.burst = 2'd0;
	end

	assign ifu_ar_xfer = ifu_ar_valid && ifu_ar_ready;
	assign lsu_ar_xfer = lsu_ar_valid && lsu_ar_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			ar_sent  <= 1'b0;
			to_clint <= 1'b0;
		end else if (ifu_done || lsu_done) begin
			ar_sent <= 1'b0;
		end else if (ifu_ar_xfer || lsu_ar_xfer) begin
			ar_sent  <= 1'b1;
			to_clint <= lsu_ar_xfer && lsu_hit_clint;
		end
	end

	////////////////////
	// read data
	////////////////////

	assign ifu_r_valid = ar_sent && ifu_own && soc_r_valid;
	assign lsu_r_valid = ar_sent && lsu_own && (to_clint ? clint_r_valid : soc_r_valid);

	assign soc_r_ready = ar_sent && (ifu_own && ifu_r_ready || lsu_own && !to_clint && lsu_r_ready);
	assign clint_r_ready = ar_sent && lsu_own && to_clint && lsu_r_ready;

	assign ifu_r = soc_r;

	always_comb begin
		if (to_clint) begin
			lsu_r.data = {32'd0, clint_r_data}; // clint words are zero extended.
			lsu_r.resp = clint_r_resp;
		end else begin
			lsu_r = soc_r;
		end
	end

	assign ifu_done = ifu_r_valid && ifu_r_ready;
	assign lsu_done = lsu_r_valid && lsu_r_ready;

	////////////////////
	// write path
	////////////////////

	always_comb begin
		soc_aw.addr  = lsu_aw.addr;
		soc_aw.size  = lsu_aw.size;
		soc_aw.id    = 4'd0;
		soc_aw.len   = 8'd0;
		soc_aw.burst = 2'd0;
		soc_w.data   = lsu_w.data;
		soc_w.strb   = lsu_w.strb;
		soc_w.last   = lsu_w_valid; // every write is a single beat.
	end

	assign soc_aw_valid = lsu_aw_valid;
	assign lsu_aw_ready = soc_aw_ready;
	assign soc_w_valid  = lsu_w_valid;
	assign lsu_w_ready  = soc_w_ready;
	assign lsu_b        = soc_b;
	assign lsu_b_valid  = soc_b_valid;
	assign soc_b_ready  = lsu_b_ready;

endmodule

// File: hdl/clint.sv
`timescale 1ns/1ns

module clint #(
	parameter int CLINT_DIVIDER = 1
) (
	input  logic                        clock,
	input  logic                        reset,
	input  logic [bus_pkg::addr_w-1:0]  ar_addr,
	input  logic                        ar_valid,
	output logic                        ar_ready,
	output logic [31:0]                 r_data,
	output bus_pkg::resp_e              r_resp,
	output logic                        r_valid,
	input  logic                        r_ready
);

	localparam logic [15:0] MTIME_LO_OFF = 16'hbff8;
	localparam logic [15:0] MTIME_HI_OFF = 16'hbffc;

	logic [31:0] prescale;
	logic        tick;
	logic [63:0] mtime;
	logic [31:0] word;
	bus_pkg::resp_e word_resp;

	////////////////////
	// mtime
	////////////////////

	assign tick = (prescale == 32'(CLINT_DIVIDER - 1));

	always_ff @(posedge clock) begin
		if (reset) begin
			prescale <= 32'd0;
			mtime    <= 64'd0;
		end else if (tick) begin
			prescale <= 32'd0;
			mtime    <= mtime + 64'd1;
		end else begin
			prescale <= prescale + 32'd1;
		end
	end

	////////////////////
	// read slave
	////////////////////

	// only the low half of the address is decoded here, the window is checked upstream.
	always_comb begin
		case (ar_addr[15:0])
			MTIME_LO_OFF: begin
				word      = mtime[31:0];
				word_resp = bus_pkg::okay;
			end
			MTIME_HI_OFF: begin
				word      = mtime[63:32];
				word_resp = bus_pkg::okay;
			end
			default: begin
				word      = 32'd0;
				word_resp = bus_pkg::decerr;
			end
		endcase
	end

	assign ar_ready = !r_valid; // one read in flight at a time.

	always_ff @(posedge clock) begin
		if (reset) begin
			r_valid <= 1'b0;
		end else if (ar_valid && ar_ready) begin
			r_valid <= 1'b1;
		end else if (r_valid && r_ready) begin
			r_valid <= 1'b0;
		end
	end

	// the word is sampled at the address transfer and held until the data is taken.
	always_ff @(posedge clock) begin
		if (ar_valid && ar_ready) begin
			r_data <= word;
			r_resp <= word_resp;
		end
	end

endmodule

// File: hdl/mem_subsystem.sv
`timescale 1ns/1ns

module mem_subsystem #(
	parameter logic [bus_pkg::addr_w-1:0] CLINT_BASE    = 32'h0200_0000,
	parameter logic [bus_pkg::addr_w-1:0] CLINT_LAST    = 32'h0200_ffff,
	parameter int                         CLINT_DIVIDER = 1
) (
	input  logic              clock,
	input  logic              reset,

	input  bus_pkg::ar_t      ifu_ar,
	input  logic              ifu_ar_valid,
	output logic              ifu_ar_ready,
	output bus_pkg::r_t       ifu_r,
	output logic              ifu_r_valid,
	input  logic              ifu_r_ready,

	input  bus_pkg::ar_t      lsu_ar,
	input  logic              lsu_ar_valid,
	output logic              lsu_ar_ready,
	output bus_pkg::r_t       lsu_r,
	output logic              lsu_r_valid,
	input  logic              lsu_r_ready,
	input  bus_pkg::aw_t      lsu_aw,
	input  logic              lsu_aw_valid,
	output logic              lsu_aw_ready,
	input  bus_pkg::w_t       lsu_w,
	input  logic              lsu_w_valid,
	output logic              lsu_w_ready,
	output bus_pkg::b_t       lsu_b,
	output logic              lsu_b_valid,
	input  logic              lsu_b_ready,

	output bus_pkg::axi_ar_t  soc_ar,
	output logic              soc_ar_valid,
	input  logic              soc_ar_ready,
	input  bus_pkg::r_t       soc_r,
	input  logic              soc_r_valid,
	output logic              soc_r_ready,
	output bus_pkg::axi_ar_t  soc_aw,
	output logic              soc_aw_valid,
	input  logic              soc_aw_ready,
	output bus_pkg::axi_w_t   soc_w,
	output logic              soc_w_valid,
	input  logic              soc_w_ready,
	input  bus_pkg::b_t       soc_b,
	input  logic              soc_b_valid,
	output logic              soc_b_ready
);

	// link between the crossbar and the clint.
	logic [bus_pkg::addr_w-1:0] clint_ar_addr;
	logic                       clint_ar_valid;
	logic                       clint_ar_ready;
	logic [31:0]                clint_r_data;
	bus_pkg::resp_e             clint_r_resp;
	logic                       clint_r_valid;
	logic                       clint_r_ready;

	xbar #(
		.CLINT_BASE (CLINT_BASE),
		.CLINT_LAST (CLINT_LAST)
	) xbar_inst (.*);

	clint #(
		.CLINT_DIVIDER (CLINT_DIVIDER)
	) clint_inst (
		.clock    (clock),
		.reset    (reset),
		.ar_addr  (clint_ar_addr),
		.ar_valid (clint_ar_valid),
		.ar_ready (clint_ar_ready),
		.r_data   (clint_r_data),
		.r_resp   (clint_r_resp),
		.r_valid  (clint_r_valid),
		.r_ready  (clint_r_ready)
	);

endmodule

// File: dv/xbar_properties.sv
`timescale 1ns/1ns

module xbar_properties (
	input logic            clock,
	input logic            reset,
	input bus_pkg::grant_e grant,
	input logic            soc_ar_valid,
	input logic            soc_ar_ready,
	input logic            clint_ar_valid,
	input logic            clint_ar_ready,
	input logic            ifu_r_valid,
	input logic            ifu_r_ready,
	input logic            lsu_r_valid,
	input logic            lsu_r_ready
);

	// an owner keeps the read path until its read data is taken.
	ifu_grant_hold: assert property (@(posedge clock) disable iff (reset)
		grant == bus_pkg::ifu_busy && !(ifu_r_valid && ifu_r_ready) |=>
		grant == bus_pkg::ifu_busy) else $error("ifu grant dropped before its read data");

	lsu_grant_hold: assert property (@(posedge clock) disable iff (reset)
		grant == bus_pkg::lsu_busy && !(lsu_r_valid && lsu_r_ready) |=>
		grant == bus_pkg::lsu_busy) else $error("lsu grant dropped before its read data");

	one_target: assert property (@(posedge clock) disable iff (reset)
		!(soc_ar_valid && clint_ar_valid)) else $error("two read targets selected");

	soc_ar_hold: assert property (@(posedge clock) disable iff (reset)
		soc_ar_valid && !soc_ar_ready |=> soc_ar_valid) else $error("soc_ar_valid dropped");

	clint_ar_hold: assert property (@(posedge clock) disable iff (reset)
		clint_ar_valid && !clint_ar_ready |=> clint_ar_valid) else $error("clint_ar_valid dropped");

	ifu_r_hold: assert property (@(posedge clock) disable iff (reset)
		ifu_r_valid && !ifu_r_ready |=> ifu_r_valid) else $error("ifu_r_valid dropped");

	lsu_r_hold: assert property (@(posedge clock) disable iff (reset)
		lsu_r_valid && !lsu_r_ready |=> lsu_r_valid) else $error("lsu_r_valid dropped");

endmodule

// File: dv/soc_slave_model.sv
`timescale 1ns/1ns

module soc_slave_model (
	input  logic              clock,
	input  logic              reset,
	input  bus_pkg::axi_ar_t  ar,
	input  logic              ar_valid,
	output logic              ar_ready,
	output bus_pkg::r_t       r,
	output logic              r_valid,
	input  logic              r_ready,
	input  bus_pkg::axi_ar_t  aw,
	input  logic              aw_valid,
	output logic              aw_ready,
	input  bus_pkg::axi_w_t   w,
	input  logic              w_valid,
	output logic              w_ready,
	output bus_pkg::b_t       b,
	output logic              b_valid,
	input  logic              b_ready
);

	logic [63:0] mem [logic [31:0]];
	logic [31:0] lfsr;
	logic [31:0] rd_addr, wr_addr;
	logic [1:0]  rd_wait;
	logic        rd_busy, aw_got, w_got;
	bus_pkg::axi_w_t wr_data;

	// fibonacci lfsr, taps 32 22 2 1.
	function automatic logic take_bit();
		lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
		return lfsr[0];
	endfunction

	function automatic logic [63:0] stored(input logic [31:0] a);
		return mem.exists(a) ? mem[a] : {a, a}; // unwritten words repeat the address.
	endfunction

	initial begin
		{ar_ready, r_valid, aw_ready, w_ready, b_valid, rd_busy, aw_got, w_got} = '0;
		r = '0;
		b = '0;
	end

	always @(posedge clock) begin
		if (reset) begin
			lfsr = 32'h6cffccba;
			{ar_ready, r_valid, aw_ready, w_ready, b_valid, rd_busy, aw_got, w_got} <= '0;
		end else begin
			if (!rd_busy) begin
				if (ar_valid && ar_ready) begin
					rd_addr  <= ar.addr;
					rd_busy  <= 1'b1;
					ar_ready <= 1'b0;
					rd_wait  <= {take_bit(), take_bit()};
				end else begin
					ar_ready <= take_bit();
				end
			end else if (!r_valid) begin
				if (rd_wait == 2'd0) begin
					r_valid <= 1'b1;
					r.data  <= stored(rd_addr);
					r.resp  <= bus_pkg::okay;
				end else begin
					rd_wait <= rd_wait - 2'd1;
				end
			end else if (r_ready) begin
				r_valid <= 1'b0;
				rd_busy <= 1'b0;
			end

			// write address and data are taken in either order.
			if (!aw_got) begin
				aw_got   <= aw_valid && aw_ready;
				wr_addr  <= aw.addr;
				aw_ready <= !(aw_valid && aw_ready) && take_bit();
			end
			if (!w_got) begin
				w_got   <= w_valid && w_ready;
				wr_data <= w;
				w_ready <= !(w_valid && w_ready) && take_bit();
			end
			if (aw_got && w_got && !b_valid) begin
				for (int i = 0; i < 8; i++) begin
					if (wr_data.strb[i]) begin
						mem[wr_addr] = stored(wr_addr);
						mem[wr_addr][i*8 +: 8] = wr_data.data[i*8 +: 8];
					end
				end
				b_valid <= 1'b1;
				b.resp  <= bus_pkg::okay;
			end else if (b_valid && b_ready) begin
				b_valid <= 1'b0;
				aw_got  <= 1'b0;
				w_got   <= 1'b0;
			end
		end
	end

endmodule

// File: dv/tb_mem_subsystem.sv
`timescale 1ns/1ns

module tb_mem_subsystem;

	localparam logic [31:0] clint_base = 32'h0200_0000;
	localparam logic [31:0] clint_last = 32'h0200_ffff;
	localparam int clint_divider = 1;
	localparam logic [2:0] op_ifu = 3'd0, op_lsu_rd = 3'd1, op_lsu_wr = 3'd2;
	localparam logic [2:0] op_both = 3'd3, op_mtime = 3'd4, op_stall = 3'd5;
	localparam int n_entries = 12;

	typedef struct packed {
		logic [2:0]     op;
		logic [31:0]    addr;
		logic [63:0]    data;
		logic [7:0]     strb;
		bus_pkg::resp_e resp;
	} entry_t;

	entry_t stim [n_entries];
	logic [63:0] shadow [logic [31:0]];
	int cycle = 0;

	logic clock = 1'b0, reset = 1'b1;
	bus_pkg::ar_t ifu_ar, lsu_ar;
	bus_pkg::r_t ifu_r, lsu_r, soc_r;
	bus_pkg::aw_t lsu_aw;
	bus_pkg::w_t lsu_w;
	bus_pkg::b_t lsu_b, soc_b;
	bus_pkg::axi_ar_t soc_ar, soc_aw;
	bus_pkg::axi_w_t soc_w;
	logic ifu_ar_valid, ifu_ar_ready, ifu_r_valid, ifu_r_ready;
	logic lsu_ar_valid, lsu_ar_ready, lsu_r_valid, lsu_r_ready;
	logic lsu_aw_valid, lsu_aw_ready, lsu_w_valid, lsu_w_ready, lsu_b_valid, lsu_b_ready;
	logic soc_ar_valid, soc_ar_ready, soc_r_valid, soc_r_ready, soc_aw_valid, soc_aw_ready;
	logic soc_w_valid, soc_w_ready, soc_b_valid, soc_b_ready;

	mem_subsystem #(.CLINT_BASE(clint_base), .CLINT_LAST(clint_last),
		.CLINT_DIVIDER(clint_divider)) mem_subsystem_inst (.*);

	soc_slave_model soc_slave_model_inst (.clock(clock), .reset(reset),
		.ar(soc_ar), .ar_valid(soc_ar_valid), .ar_ready(soc_ar_ready),
		.r(soc_r), .r_valid(soc_r_valid), .r_ready(soc_r_ready),
		.aw(soc_aw), .aw_valid(soc_aw_valid), .aw_ready(soc_aw_ready),
		.w(soc_w), .w_valid(soc_w_valid), .w_ready(soc_w_ready),
		.b(soc_b), .b_valid(soc_b_valid), .b_ready(soc_b_ready));

	bind xbar xbar_properties xbar_properties_inst (.*);

	always #2 clock = ~clock;
	always @(posedge clock) cycle <= cycle + 1;

	function automatic logic [63:0] expect_word(input logic [31:0] a);
		if (a >= clint_base && a <= clint_last) return 64'd0; // only unmapped offsets here.
		return shadow.exists(a) ? shadow[a] : {a, a};
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "first error ends the run");
	endtask

	task automatic check_r(input string name, input bus_pkg::r_t got, input bus_pkg::r_t exp);
		if (got !== exp) stop_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_b(input string name, input bus_pkg::b_t got, input bus_pkg::b_t exp);
		if (got !== exp) stop_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_ar(input string name, input bus_pkg::axi_ar_t got,
			input bus_pkg::axi_ar_t exp);
		if (got !== exp) stop_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_w(input string name, input bus_pkg::axi_w_t got,
			input bus_pkg::axi_w_t exp);
		if (got !== exp) stop_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	////////////////////
	// masters
	////////////////////

	// all tasks start on a falling edge and sample 1 ns later, away from the rising edge.
	task automatic ifu_read(input logic [31:0] a, output bus_pkg::r_t r, output int done);
		logic fire;
		ifu_ar.addr = a;
		ifu_ar.size = 3'b011; // the crossbar must force the fetch size.
		ifu_ar_valid = 1'b1;
		ifu_r_ready = 1'b1;
		do begin
			#1 fire = ifu_ar_ready;
			if (fire) check_ar("soc_ar", soc_ar, {a, 4'd0, 8'd0, 3'b010, 2'd0});
			@(negedge clock);
		end while (!fire);
		ifu_ar_valid = 1'b0;
		do begin
			#1 fire = ifu_r_valid;
			r = ifu_r;
			done = cycle;
			@(negedge clock);
		end while (!fire);
		ifu_r_ready = 1'b0;
	endtask

	task automatic lsu_read(input logic [31:0] a, input int hold, output bus_pkg::r_t r,
			output int done);
		logic fire;
		logic to_clint;
		logic stalled;
		to_clint = (a >= clint_base && a <= clint_last);
		lsu_ar.addr = a;
		lsu_ar.size = 3'b011;
		lsu_ar_valid = 1'b1;
		lsu_r_ready = (hold == 0);
		do begin
			#1 fire = lsu_ar_ready;
			if (to_clint && soc_ar_valid) stop_run("clint read reached the SoC port");
			if (fire && !to_clint) check_ar("soc_ar", soc_ar, {a, 4'd0, 8'd0, 3'b011, 2'd0});
			@(negedge clock);
		end while (!fire);
		lsu_ar_valid = 1'b0;
		do begin
			#1 fire = lsu_r_valid && lsu_r_ready;
			r = lsu_r;
			done = cycle;
			stalled = lsu_r_valid && !lsu_r_ready;
			if (stalled) begin
				for (int k = 0; k < hold; k++) begin
					@(negedge clock);
					#1 check_r("lsu_r held", lsu_r, r);
					if (!lsu_r_valid) stop_run("lsu_r_valid fell while lsu_r_ready was low");
					if (ifu_ar_ready) stop_run("ifu granted during an lsu stall");
				end
			end
			@(negedge clock);
			if (stalled) lsu_r_ready = 1'b1;
		end while (!fire);
		lsu_r_ready = 1'b0;
	endtask

	task automatic lsu_write(input entry_t e, output bus_pkg::b_t b);
		logic aw_fire, w_fire;
		lsu_aw.addr = e.addr;
		lsu_aw.size = 3'b011;
		lsu_w.data = e.data;
		lsu_w.strb = e.strb;
		lsu_aw_valid = 1'b1;
		lsu_w_valid = 1'b1;
		lsu_b_ready = 1'b1;
		while (lsu_aw_valid || lsu_w_valid) begin
			#1 aw_fire = lsu_aw_valid && lsu_aw_ready;
			w_fire = lsu_w_valid && lsu_w_ready;
			if (aw_fire) check_ar("soc_aw", soc_aw, {e.addr, 4'd0, 8'd0, 3'b011, 2'd0});
			if (w_fire) check_w("soc_w", soc_w, {e.data, e.strb, 1'b1});
			@(negedge clock);
			if (aw_fire) lsu_aw_valid = 1'b0;
			if (w_fire) lsu_w_valid = 1'b0;
		end
		do begin
			#1 aw_fire = lsu_b_valid;
			b = lsu_b;
			@(negedge clock);
		end while (!aw_fire);
		lsu_b_ready = 1'b0;
	endtask

	////////////////////
	// run
	////////////////////

	initial begin
		repeat (n_entries * 64) @(posedge clock);
		$display("watchdog expired before the table finished");
		$display("RESULT: FAIL");
		$fatal(1, "timeout");
	end

	initial begin
		bus_pkg::r_t r1, r2;
		bus_pkg::b_t b1;
		int c1, c2;
		logic [63:0] merged;
		{ifu_ar, lsu_ar, lsu_aw, lsu_w} = '0;
		{ifu_ar_valid, ifu_r_ready, lsu_ar_valid, lsu_r_ready} = '0;
		{lsu_aw_valid, lsu_w_valid, lsu_b_ready} = '0;
		stim[0]  = '{op_ifu, 32'h8000_0000, 64'd0, 8'h00, bus_pkg::okay};
		stim[1]  = '{op_lsu_wr, 32'h8000_0100, 64'h1122_3344_5566_7788, 8'hff, bus_pkg::okay};
		stim[2]  = '{op_lsu_rd, 32'h8000_0100, 64'd0, 8'h00, bus_pkg::okay};
		stim[3]  = '{op_lsu_wr, 32'h8000_0100, 64'haabb_ccdd_eeff_0011, 8'h0f, bus_pkg::okay};
		stim[4]  = '{op_lsu_rd, 32'h8000_0100, 64'd0, 8'h00, bus_pkg::okay};
		stim[5]  = '{op_lsu_wr, 32'h8000_0200, 64'hdead_beef_0bad_f00d, 8'hf0, bus_pkg::okay};
		stim[6]  = '{op_lsu_rd, 32'h8000_0200, 64'd0, 8'h00, bus_pkg::okay};
		stim[7]  = '{op_both, 32'h8000_0040, 64'd0, 8'h00, bus_pkg::okay};
		stim[8]  = '{op_mtime, clint_base + 32'h0000_bff8, 64'd0, 8'h00, bus_pkg::okay};
		stim[9]  = '{op_lsu_rd, clint_base + 32'h0000_0010, 64'd0, 8'h00, bus_pkg::decerr};
		stim[10] = '{op_stall, 32'h8000_0300, 64'd0, 8'h00, bus_pkg::okay};
		stim[11] = '{op_ifu, 32'h8000_0100, 64'd0, 8'h00, bus_pkg::okay};
		repeat (16) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		foreach (stim[i]) begin
			case (stim[i].op)
				op_ifu: begin
					ifu_read(stim[i].addr, r1, c1);
					check_r("ifu_r", r1, {expect_word(stim[i].addr), stim[i].resp});
				end
				op_lsu_rd: begin
					lsu_read(stim[i].addr, 0, r1, c1);
					check_r("lsu_r", r1, {expect_word(stim[i].addr), stim[i].resp});
				end
				op_lsu_wr: begin
					lsu_write(stim[i], b1);
					check_b("lsu_b", b1, stim[i].resp);
					merged = expect_word(stim[i].addr);
					for (int k = 0; k < 8; k++)
						if (stim[i].strb[k]) merged[k*8 +: 8] = stim[i].data[k*8 +: 8];
					shadow[stim[i].addr] = merged;
				end
				op_both, op_stall: begin
					fork
						begin
							if (stim[i].op == op_stall) repeat (3) @(negedge clock);
							ifu_read(stim[i].addr, r1, c1);
						end
						lsu_read(stim[i].addr + 32'd8, (stim[i].op == op_stall) ? 6 : 0, r2, c2);
					join
					check_r("ifu_r", r1, {expect_word(stim[i].addr), stim[i].resp});
					check_r("lsu_r", r2, {expect_word(stim[i].addr + 32'd8), stim[i].resp});
					if ((stim[i].op == op_both) != (c1 < c2)) stop_run("reads finished in wrong order");
				end
				default: begin
					lsu_read(stim[i].addr, 0, r1, c1);
					repeat (5) @(negedge clock);
					lsu_read(stim[i].addr, 0, r2, c2);
					if (r1.resp !== bus_pkg::okay || r2.resp !== bus_pkg::okay)
						stop_run($sformatf("[FAIL] mtime resp got %h and %h", r1.resp, r2.resp));
					if (r2.data < r1.data || r2.data - r1.data > 64'((c2 - c1) / clint_divider))
						stop_run($sformatf("[FAIL] mtime got %h then %h over %0d cycles",
							r1.data, r2.data, c2 - c1));
				end
			endcase
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: list.f
hdl/bus_pkg.sv
hdl/read_arbiter.sv
hdl/xbar.sv
hdl/clint.sv
hdl/mem_subsystem.sv
dv/xbar_properties.sv
dv/soc_slave_model.sv
dv/tb_mem_subsystem.sv

// File: run.sh
#!/bin/sh
# build and run the testbench; the exit status is the simulator's.
verilator --binary --timing --assert -j 0 -f list.f --top-module tb_mem_subsystem -o sim_tb \
	&& ./obj_dir/sim_tb \
	|| exit 1
